// File: logic/scan_pkg.sv
`default_nettype none

package scan_pkg;

  // scan timing
  // clock cycles between two ticks
  localparam int LINE_PERIOD = 40;
  // ticks per frame, the last one is the frame event
  localparam int LINES_PER_FRAME = 6;
  // pixel words following each line header
  localparam int PIXELS_PER_LINE = 8;

  // output buffer
  localparam int FIFO_DEPTH = 16;

  // derived widths
  localparam int PERIOD_W = $clog2(LINE_PERIOD);
  localparam int POS_W = $clog2(LINES_PER_FRAME);
  localparam int COL_W = $clog2(PIXELS_PER_LINE);
  localparam int FIFO_AW = $clog2(FIFO_DEPTH);
  // count must reach FIFO_DEPTH itself
  localparam int FIFO_CW = $clog2(FIFO_DEPTH + 1);

  // word payload layout
  localparam int PAYLOAD_W = 14;
  // pixel payload is line index over column
  localparam int LINE_FIELD_W = 6;
  localparam int COL_FIELD_W = 8;

  // kind tag of a word in the stream
  typedef enum logic [1:0] {
    KIND_LINE  = 2'd0,
    KIND_PIXEL = 2'd1,
    KIND_FRAME = 2'd2
  } word_kind_t;

  // one FIFO entry
  typedef struct packed {
    word_kind_t kind;
    logic [PAYLOAD_W-1:0] payload;
  } scan_word_t;

  // request levels from the timing generator
  typedef struct packed {
    logic line;
    logic frame;
  } scan_req_t;

  // done pulses from the packer
  typedef struct packed {
    logic line_done;
    logic frame_done;
  } scan_ack_t;

  // packer FSM
  typedef enum logic [1:0] {
    PK_IDLE   = 2'd0,
    PK_HEADER = 2'd1,
    PK_PIXELS = 2'd2,
    PK_MARKER = 2'd3
  } packer_state_t;

endpackage

`default_nettype wire

// File: logic/scan_timing_gen.sv
`timescale 1ns/1ps
`default_nettype none

// free running stand-in for the mirror timing
// one tick every LINE_PERIOD cycles, last tick of a frame is the frame event
module scan_timing_gen
  import scan_pkg::*;
(
  input  wire logic      clk,
  input  wire logic      rst,
  input  wire scan_ack_t ack,
  output scan_req_t      req,
  output logic           overrun
);

  // cycle counter within one line period
  logic [PERIOD_W-1:0] cnt_d, cnt_q;
  // tick position within the frame
  logic [POS_W-1:0] pos_d, pos_q;
  scan_req_t req_d, req_q;
  logic overrun_d, overrun_q;

  // tick strobe
  logic tick;
  // current tick is the frame slot
  logic frame_slot;
  // any request still waiting for done
  logic pending;

  assign tick = (cnt_q == PERIOD_W'(LINE_PERIOD - 1));
  assign frame_slot = (pos_q == POS_W'(LINES_PER_FRAME - 1));
  assign pending = req_q.line | req_q.frame;

  assign req = req_q;
  assign overrun = overrun_q;

  always_comb begin
    // hold by default
    cnt_d = cnt_q;
    pos_d = pos_q;
    req_d = req_q;
    overrun_d = overrun_q;

    // done drops the matching level next cycle
    if (ack.line_done) begin
      req_d.line = 1'b0;
    end
    if (ack.frame_done) begin
      req_d.frame = 1'b0;
    end

    if (tick) begin
      cnt_d = '0;
      // position keeps counting even when the event is dropped
      if (frame_slot) begin
        pos_d = '0;
      end else begin
        pos_d = pos_q + 1'b1;
      end

      if (pending) begin
        // consumer too slow, lose this event
        overrun_d = 1'b1;
      end else if (frame_slot) begin
        req_d.frame = 1'b1;
      end else begin
        req_d.line = 1'b1;
      end
    end else begin
      cnt_d = cnt_q + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      cnt_q <= '0;
      pos_q <= '0;
      req_q <= '0;
      overrun_q <= 1'b0;
    end else begin
      cnt_q <= cnt_d;
      pos_q <= pos_d;
      req_q <= req_d;
      overrun_q <= overrun_d;
    end
  end

  // one request kind at a time
  a_req_exclusive : assert property (
    @(posedge clk) disable iff (rst)
    !(req.line && req.frame)
  );

  // packer may only answer a raised request
  a_done_needs_req : assert property (
    @(posedge clk) disable iff (rst)
    (ack.line_done |-> req.line) and (ack.frame_done |-> req.frame)
  );

endmodule

`default_nettype wire

// File: logic/line_packer.sv
`timescale 1ns/1ps
`default_nettype none

// turns line and frame requests into scan words for the FIFO
// line is one header then PIXELS_PER_LINE pixels, frame is one marker
module line_packer
  import scan_pkg::*;
(
  input  wire logic      clk,
  input  wire logic      rst,
  input  wire scan_req_t req,
  input  wire logic      full,
  output scan_ack_t      ack,
  output logic           wr_en,
  output scan_word_t     wr_word
);

  packer_state_t state_d, state_q;

  // line index within the frame
  logic [POS_W-1:0] line_d, line_q;
  // pixel column within the line
  logic [COL_W-1:0] col_d, col_q;
  // frame marker count, wraps at 2^14
  logic [PAYLOAD_W-1:0] frame_d, frame_q;

  // a word is offered in every non idle state
  logic busy;
  // last pixel column reached
  logic last_col;

  assign busy = (state_q != PK_IDLE);
  assign last_col = (col_q == COL_W'(PIXELS_PER_LINE - 1));

  // stall on full, word stays put
  assign wr_en = busy & ~full;

  always_comb begin
    state_d = state_q;
    line_d = line_q;
    col_d = col_q;
    frame_d = frame_q;
    ack = '0;
    wr_word.kind = KIND_LINE;
    wr_word.payload = '0;

    case (state_q)
      PK_IDLE: begin
        // line first, though both never show together
        if (req.line) begin
          state_d = PK_HEADER;
        end else if (req.frame) begin
          state_d = PK_MARKER;
        end
      end

      PK_HEADER: begin
        wr_word.kind = KIND_LINE;
        wr_word.payload = PAYLOAD_W'(line_q);
        if (!full) begin
          col_d = '0;
          state_d = PK_PIXELS;
        end
      end

      PK_PIXELS: begin
        // line index over column
        wr_word.kind = KIND_PIXEL;
        wr_word.payload = {LINE_FIELD_W'(line_q), COL_FIELD_W'(col_q)};
        if (!full) begin
          if (last_col) begin
            // done together with the last pixel
            ack.line_done = 1'b1;
            line_d = line_q + 1'b1;
            state_d = PK_IDLE;
          end else begin
            col_d = col_q + 1'b1;
          end
        end
      end

      PK_MARKER: begin
        wr_word.kind = KIND_FRAME;
        wr_word.payload = frame_q;
        if (!full) begin
          ack.frame_done = 1'b1;
          frame_d = frame_q + 1'b1;
          // next frame starts at line 0
          line_d = '0;
          state_d = PK_IDLE;
        end
      end

      default: begin
        state_d = PK_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q <= PK_IDLE;
      line_q <= '0;
      col_q <= '0;
      frame_q <= '0;
    end else begin
      state_q <= state_d;
      line_q <= line_d;
      col_q <= col_d;
      frame_q <= frame_d;
    end
  end

  // full comes from the FIFO, never push into it
  a_no_write_when_full : assert property (
    @(posedge clk) disable iff (rst)
    full |-> !wr_en
  );

endmodule

`default_nettype wire

// File: logic/sync_fifo.sv
`timescale 1ns/1ps
`default_nettype none

// show-ahead FIFO of scan words
// head word sits on rd_word while empty is low
module sync_fifo
  import scan_pkg::*;
(
  input  wire logic       clk,
  input  wire logic       rst,
  input  wire logic       wr_en,
  input  wire scan_word_t wr_word,
  input  wire logic       rd_en,
  output scan_word_t      rd_word,
  output logic            full,
  output logic            empty
);

  // storage
  scan_word_t mem [FIFO_DEPTH];

  logic [FIFO_AW-1:0] wr_ptr, rd_ptr;
  logic [FIFO_CW-1:0] count;

  // accepted transfers
  logic do_wr;
  logic do_rd;

  // writes into a full FIFO and reads from an empty one are ignored
  assign do_wr = wr_en & ~full;
  assign do_rd = rd_en & ~empty;

  assign full = (count == FIFO_CW'(FIFO_DEPTH));
  assign empty = (count == '0);

  // head of queue straight from the array
  assign rd_word = mem[rd_ptr];

  always_ff @(posedge clk) begin
    if (do_wr) begin
      mem[wr_ptr] <= wr_word;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count <= '0;
    end else begin
      // pointers wrap at the last entry
      if (do_wr) begin
        wr_ptr <= (wr_ptr == FIFO_AW'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (do_rd) begin
        rd_ptr <= (rd_ptr == FIFO_AW'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      // simultaneous push and pop leave count alone
      case ({do_wr, do_rd})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // occupancy stays within the array
  a_count_bound : assert property (
    @(posedge clk) disable iff (rst)
    count <= FIFO_CW'(FIFO_DEPTH)
  );

endmodule

`default_nettype wire

// File: logic/fake_scanner_top.sv
`timescale 1ns/1ps
`default_nettype none

// scanner subsystem
// timing generator feeds the packer, packer fills the FIFO, reader drains it
module fake_scanner_top
  import scan_pkg::*;
(
  input  wire logic clk,
  input  wire logic rst,
  input  wire logic rd_en,
  output scan_word_t rd_word,
  output logic      empty,
  output logic      overrun
);

  // request levels and done pulses
  scan_req_t req;
  scan_ack_t ack;

  // packer to FIFO
  logic       wr_en;
  scan_word_t wr_word;
  logic       full;

  scan_timing_gen u_timing (
    .clk     (clk),
    .rst     (rst),
    .ack     (ack),
    .req     (req),
    .overrun (overrun)
  );

  line_packer u_packer (
    .clk     (clk),
    .rst     (rst),
    .req     (req),
    .full    (full),
    .ack     (ack),
    .wr_en   (wr_en),
    .wr_word (wr_word)
  );

  // show-ahead output buffer
  sync_fifo u_fifo (
    .clk     (clk),
    .rst     (rst),
    .wr_en   (wr_en),
    .wr_word (wr_word),
    .rd_en   (rd_en),
    .rd_word (rd_word),
    .full    (full),
    .empty   (empty)
  );

endmodule

`default_nettype wire

// File: bench/tb_fake_scanner.sv
`timescale 1ns/1ps
`default_nettype none

// testbench for the scanner subsystem
// random reads against a word stream model built from the packing rules
module tb_fake_scanner
  import scan_pkg::*;
();

  localparam int CLK_HALF = 20;
  localparam int RST_CYCLES = 16;
  // frames held in the model queue, more than the tests pop
  localparam int STREAM_FRAMES = 8;
  // test lengths in line periods: reset, word order, back-pressure, overrun
  localparam int TEST_PERIODS = 2 + 20 + 16 + 12;
  localparam int MARGIN_PERIODS = 10;
  localparam int WATCHDOG_NS = (TEST_PERIODS + MARGIN_PERIODS) * LINE_PERIOD * 2 * CLK_HALF;

  logic clk;
  logic rst;
  logic rd_en;
  scan_word_t rd_word;
  logic empty;
  logic overrun;

  // random source state
  logic [15:0] lfsr;
  int err_count;
  int test_count;
  int fail_tests;
  // expected words in pop order
  scan_word_t exp_q[$];
  // frame markers popped so far
  int markers_seen;
  // word after a marker must be line 0 header
  logic expect_line0;

  fake_scanner_top DUT (
    .clk     (clk),
    .rst     (rst),
    .rd_en   (rd_en),
    .rd_word (rd_word),
    .empty   (empty),
    .overrun (overrun)
  );

  always #CLK_HALF clk = ~clk;

  // 16 bit Galois LFSR, taps 16 14 13 11
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    logic lsb;
    lsb = s[0];
    s = s >> 1;
    if (lsb) begin
      s = s ^ 16'hB400;
    end
    return s;
  endfunction

  // one LFSR step per bit
  task automatic take_bits(input int n, output int val);
    val = 0;
    for (int k = 0; k < n; k++) begin
      lfsr = lfsr_next(lfsr);
      val = (val << 1) | int'(lfsr[0]);
    end
  endtask

  task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("ERR %s got 0x%0h expected 0x%0h", name, got, exp);
      err_count++;
    end
  endtask

  // header, pixels per line, then one marker per frame
  task automatic build_stream(input int nframes);
    scan_word_t w;
    for (int f = 0; f < nframes; f++) begin
      for (int i = 0; i < LINES_PER_FRAME - 1; i++) begin
        w.kind = KIND_LINE;
        w.payload = 14'(i);
        exp_q.push_back(w);
        for (int c = 0; c < PIXELS_PER_LINE; c++) begin
          w.kind = KIND_PIXEL;
          // line index in upper 6 bits, column in lower 8
          w.payload = 14'((i << 8) | c);
          exp_q.push_back(w);
        end
      end
      w.kind = KIND_FRAME;
      w.payload = 14'(f);
      exp_q.push_back(w);
    end
  endtask

  // compare the head word that the next edge pops
  task automatic pop_word();
    scan_word_t exp;
    if (exp_q.size() == 0) begin
      $display("model stream ran out of expected words");
      err_count++;
    end else begin
      exp = exp_q.pop_front();
      check("rd_word.kind", 32'(rd_word.kind), 32'(exp.kind));
      check("rd_word.payload", 32'(rd_word.payload), 32'(exp.payload));
      if (expect_line0) begin
        check("rd_word after marker", 32'(rd_word), 32'({KIND_LINE, 14'h0}));
        expect_line0 = 1'b0;
      end
      if (rd_word.kind == KIND_FRAME) begin
        // marker count starts at 0
        check("frame marker payload", 32'(rd_word.payload), 32'(markers_seen));
        markers_seen++;
        expect_line0 = 1'b1;
      end
    end
  endtask

  // drive on the rising edge, look at the outputs on the falling edge
  task automatic tick_cycle(input logic rd);
    @(posedge clk);
    rd_en <= rd;
    @(negedge clk);
    if (rd_en && !empty) begin
      pop_word();
    end
  endtask

  // first cycle still shows the state from before rst
  task automatic apply_reset();
    for (int i = 0; i < RST_CYCLES; i++) begin
      @(posedge clk);
      rst <= 1'b1;
      rd_en <= 1'b0;
      @(negedge clk);
      if (i > 0) begin
        check("empty", 32'(empty), 32'd1);
        check("overrun", 32'(overrun), 32'd0);
      end
    end
    @(posedge clk);
    rst <= 1'b0;
  endtask

  task automatic report_test(input string name, input int errs_before);
    test_count++;
    if (err_count == errs_before) begin
      $display("test %s: ok", name);
    end else begin
      fail_tests++;
      $display("test %s: %0d errors", name, err_count - errs_before);
    end
  endtask

  initial begin
    int errs_before;
    int bit_val;
    int stall;
    int burst;
    int target;

    clk = 1'b0;
    rst = 1'b1;
    rd_en = 1'b0;
    lfsr = 16'd29;
    err_count = 0;
    test_count = 0;
    fail_tests = 0;
    markers_seen = 0;
    expect_line0 = 1'b0;
    build_stream(STREAM_FRAMES);

    // reset state, no word before the first tick
    errs_before = err_count;
    apply_reset();
    for (int i = 0; i < LINE_PERIOD - 1; i++) begin
      tick_cycle(1'b0);
      check("empty", 32'(empty), 32'd1);
      check("overrun", 32'(overrun), 32'd0);
    end
    report_test("reset_state", errs_before);

    // word order over three frames, reads on about half the cycles
    errs_before = err_count;
    while (markers_seen < 3) begin
      take_bits(1, bit_val);
      tick_cycle(bit_val[0]);
    end
    report_test("word_order", errs_before);

    // stalls of 5 to 20 cycles, then read bursts long enough to drain
    errs_before = err_count;
    target = markers_seen + 2;
    while (markers_seen < target) begin
      take_bits(4, stall);
      repeat (stall + 5) begin
        tick_cycle(1'b0);
      end
      take_bits(4, burst);
      repeat (burst + 16) begin
        tick_cycle(1'b1);
      end
    end
    check("overrun", 32'(overrun), 32'd0);
    report_test("back_pressure", errs_before);

    // no reads for 10 line periods, FIFO fills and a request misses a tick
    errs_before = err_count;
    repeat (10 * LINE_PERIOD) begin
      tick_cycle(1'b0);
    end
    check("overrun", 32'(overrun), 32'd1);
    apply_reset();
    @(negedge clk);
    check("overrun", 32'(overrun), 32'd0);
    check("empty", 32'(empty), 32'd1);
    report_test("overrun", errs_before);

    $display("tests %0d, failed tests %0d, errors %0d", test_count, fail_tests, err_count);
    if (err_count == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

  // bound on total run time
  initial begin
    #(WATCHDOG_NS);
    $display("watchdog expired after %0d ns, tests did not finish", WATCHDOG_NS);
    $display("Simulation failed");
    $finish;
  end

endmodule

`default_nettype wire

// File: list.f
logic/scan_pkg.sv
logic/scan_timing_gen.sv
logic/line_packer.sv
logic/sync_fifo.sv
logic/fake_scanner_top.sv
bench/tb_fake_scanner.sv

// File: Bender.yml
package:
  name: fake_scanner

sources:
  - files:
      - logic/scan_pkg.sv
      - logic/scan_timing_gen.sv
      - logic/line_packer.sv
      - logic/sync_fifo.sv
      - logic/fake_scanner_top.sv
  - target: simulation
    files:
      - bench/tb_fake_scanner.sv
